// File: tb.f
src/aes_pkg.sv
src/aes_addr_counter.sv
src/aes_regfile.sv
src/aes_fsm.sv
src/aes_stream_source.sv
src/aes_add_round_key.sv
src/aes_stream_sink.sv
src/aes_accel_top.sv
verification/tb_aes_accel.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_aes_accel -f tb.f -o tb_aes_accel

# The simulator exits non-zero on a fatal check, so keep going to the log scan
./obj_dir/tb_aes_accel > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"

// File: verification/tb_aes_accel.sv
module tb_aes_accel;

  localparam int MEM_WORDS   = 1024;
  localparam int NUM_JOBS    = 6;
  localparam int JOB_TIMEOUT = 2000;

  typedef struct packed {
    logic [31:0]  src;
    logic [31:0]  dst;
    logic [15:0]  num;
    // Key word k sits at bits 32k upward
    logic [127:0] key;
    // Extra trigger and key write while the job runs
    logic         extra;
  } job_t;

  logic        clk;
  logic        reset_n;
  logic        cfg_we_i;
  logic [3:0]  cfg_addr_i;
  logic [31:0] cfg_wdata_i;
  logic [31:0] cfg_rdata_o;
  logic        rd_req_o;
  logic [31:0] rd_addr_o;
  logic [31:0] rd_data_i;
  logic        wr_req_o;
  logic [31:0] wr_addr_o;
  logic [31:0] wr_data_o;
  logic        done_o;

  logic [31:0] mem [0:MEM_WORDS-1];
  job_t        jobs [NUM_JOBS];
  logic [31:0] cur_src;
  logic [31:0] cur_dst;
  logic [31:0] cur_bytes;
  int          rd_count;
  int          wr_count;
  integer      seed;

  aes_accel_top #(.CNT_W(16)) i_aes_accel_top (
    .clk         (clk),
    .reset_n     (reset_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .rd_req_o    (rd_req_o),
    .rd_addr_o   (rd_addr_o),
    .rd_data_i   (rd_data_i),
    .wr_req_o    (wr_req_o),
    .wr_addr_o   (wr_addr_o),
    .wr_data_o   (wr_data_o),
    .done_o      (done_o)
  );

  always #5 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic [9:0] word_slot(input logic [31:0] base, input int k);
    return 10'((base >> 2) + 32'(k));
  endfunction

  // Memory model, read data one cycle after the request
  always @(posedge clk) begin
    if (rd_req_o) begin
      assert (rd_addr_o >= cur_src && rd_addr_o < cur_src + cur_bytes)
        else report_failure($sformatf("FAILED at %0t: read address %h outside source range",
                                      $time, rd_addr_o));
      rd_data_i <= mem[rd_addr_o[11:2]];
      rd_count = rd_count + 1;
    end
    if (wr_req_o) begin
      assert (wr_addr_o >= cur_dst && wr_addr_o < cur_dst + cur_bytes)
        else report_failure($sformatf("FAILED at %0t: write address %h outside destination range",
                                      $time, wr_addr_o));
      mem[wr_addr_o[11:2]] = wr_data_o;
      wr_count = wr_count + 1;
    end
  end

  task automatic write_reg(input logic [3:0] idx, input logic [31:0] data);
    @(posedge clk);
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= idx;
    cfg_wdata_i <= data;
    @(posedge clk);
    cfg_we_i    <= 1'b0;
  endtask

  task automatic run_job(input int j);
    job_t        job;
    int          cycles;
    int          nwords;
    int          k;
    logic        seen_done;
    logic [31:0] expected;
    logic [31:0] got;
    job       = jobs[j];
    nwords    = int'(job.num) * 4;
    cur_src   = job.src;
    cur_dst   = job.dst;
    cur_bytes = 32'(nwords) * 32'd4;
    rd_count  = 0;
    wr_count  = 0;
    write_reg(aes_pkg::REG_SRC_BASE, job.src);
    write_reg(aes_pkg::REG_DST_BASE, job.dst);
    write_reg(aes_pkg::REG_NUM_BLOCKS, 32'(job.num));
    for (k = 0; k < 4; k++) begin
      write_reg(aes_pkg::REG_KEY0 + 4'(k), job.key[32*k +: 32]);
    end
    @(posedge clk);
    cfg_we_i   <= 1'b1;
    cfg_addr_i <= aes_pkg::REG_TRIGGER;
    cycles    = 0;
    seen_done = 1'b0;
    while (!seen_done && cycles < JOB_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      cfg_we_i   <= 1'b0;
      cfg_addr_i <= aes_pkg::REG_STATUS;
      // Both writes land while the job is busy and must be ignored
      if (job.extra && cycles == 2) begin
        cfg_we_i   <= 1'b1;
        cfg_addr_i <= aes_pkg::REG_TRIGGER;
      end
      if (job.extra && cycles == 4) begin
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= aes_pkg::REG_KEY0;
        cfg_wdata_i <= ~job.key[31:0];
      end
      @(negedge clk);
      if (!cfg_we_i) begin
        assert (cfg_rdata_o == 32'd1)
          else report_failure($sformatf("FAILED at %0t: job %0d status %h, expected busy",
                                        $time, j, cfg_rdata_o));
      end
      seen_done = done_o;
    end
    if (!seen_done) begin
      report_failure($sformatf("Timeout while waiting for done_o in job %0d", j));
    end
    @(posedge clk);
    @(negedge clk);
    assert (!done_o)
      else report_failure($sformatf("FAILED at %0t: done_o high longer than one cycle", $time));
    assert (cfg_rdata_o == 32'd0)
      else report_failure($sformatf("FAILED at %0t: status %h after done", $time, cfg_rdata_o));
    repeat (6) begin
      @(negedge clk);
      assert (!done_o && !rd_req_o && !wr_req_o)
        else report_failure($sformatf("FAILED at %0t: activity after job %0d ended", $time, j));
    end
    if (job.num == 16'd0) begin
      assert (cycles == 3)
        else report_failure($sformatf("FAILED at %0t: zero job done after %0d cycles",
                                      $time, cycles));
    end
    assert (rd_count == nwords && wr_count == nwords)
      else report_failure($sformatf("FAILED at %0t: job %0d made %0d reads, %0d writes",
                                    $time, j, rd_count, wr_count));
    for (k = 0; k < nwords; k++) begin
      got      = mem[word_slot(job.dst, k)];
      expected = mem[word_slot(job.src, k)] ^ job.key[32*(k % 4) +: 32];
      assert (got == expected)
        else report_failure($sformatf("FAILED at %0t: job %0d word %0d is %h, expected %h",
                                      $time, j, k, got, expected));
    end
  endtask

  initial begin
    int i;
    clk         = 1'b0;
    reset_n     <= 1'b0;
    cfg_we_i    <= 1'b0;
    cfg_addr_i  <= '0;
    cfg_wdata_i <= '0;
    rd_data_i   <= '0;
    cur_src     = '0;
    cur_dst     = '0;
    cur_bytes   = '0;
    rd_count    = 0;
    wr_count    = 0;
    seed        = 32'h580a_3135;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem[10'(i)] = $random(seed);
    end
    // Source, destination, blocks, key words 3 down to 0, extra trigger
    jobs[0] = '{32'h0000_0000, 32'h0000_0800, 16'd1,
                128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0, 1'b0};
    jobs[1] = '{32'h0000_0100, 32'h0000_0900, 16'd5,
                128'h11111111_22222222_44444444_88888888, 1'b0};
    jobs[2] = '{32'h0000_0200, 32'h0000_0a00, 16'd0,
                128'hdeadbeef_cafef00d_01234567_89abcdef, 1'b0};
    jobs[3] = '{32'h0000_0300, 32'h0000_0b00, 16'd3,
                128'ha5a5a5a5_5a5a5a5a_ffff0000_0000ffff, 1'b1};
    jobs[4] = '{32'h0000_0400, 32'h0000_0c00, 16'd2,
                128'h2b7e1516_28aed2a6_abf71588_09cf4f3c, 1'b0};
    jobs[5] = '{32'h0000_0500, 32'h0000_0d00, 16'd2,
                128'h3c4fcf09_8815f7ab_a6d2ae28_16157e2b, 1'b0};
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    assert (!done_o && !rd_req_o && !wr_req_o)
      else report_failure($sformatf("FAILED at %0t: outputs active after reset", $time));
    // Every register reads zero out of reset, status included
    for (i = 0; i <= 8; i++) begin
      @(posedge clk);
      cfg_addr_i <= 4'(i);
      @(negedge clk);
      assert (cfg_rdata_o == 32'd0)
        else report_failure($sformatf("FAILED at %0t: register %0d reads %h after reset",
                                      $time, i, cfg_rdata_o));
    end
    for (i = 0; i < NUM_JOBS; i++) begin
      run_job(i);
    end
    $display("Test passed");
    $finish;
  end

endmodule

// File: src/aes_accel_top.sv
module aes_accel_top #(
  parameter int unsigned CNT_W = 16
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              cfg_we_i,
  input  aes_pkg::reg_idx_t cfg_addr_i,
  input  aes_pkg::word_t    cfg_wdata_i,
  output aes_pkg::word_t    cfg_rdata_o,
  output logic              rd_req_o,
  output aes_pkg::addr_t    rd_addr_o,
  input  aes_pkg::word_t    rd_data_i,
  output logic              wr_req_o,
  output aes_pkg::addr_t    wr_addr_o,
  output aes_pkg::word_t    wr_data_o,
  output logic              done_o
);

  logic             start;
  logic             busy;
  logic             stream_start;
  logic             engine_clear;
  logic             src_done;
  logic             snk_done;
  logic             eng_full;
  logic             take;
  logic             blk_valid;
  aes_pkg::block_t  blk_data;
  aes_pkg::block_t  eng_block;
  aes_pkg::addr_t   src_base;
  aes_pkg::addr_t   dst_base;
  logic [CNT_W-1:0] num_blocks;
  aes_pkg::block_t  key;

  aes_regfile #(.CNT_W(CNT_W)) i_regfile (
    .clk          (clk),
    .reset_n      (reset_n),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .busy_i       (busy),
    .cfg_rdata_o  (cfg_rdata_o),
    .start_o      (start),
    .src_base_o   (src_base),
    .dst_base_o   (dst_base),
    .num_blocks_o (num_blocks),
    .key_o        (key)
  );

  aes_fsm i_fsm (
    .clk            (clk),
    .reset_n        (reset_n),
    .start_i        (start),
    .src_done_i     (src_done),
    .snk_done_i     (snk_done),
    .eng_full_i     (eng_full),
    .stream_start_o (stream_start),
    .engine_clear_o (engine_clear),
    .busy_o         (busy),
    .done_o         (done_o)
  );

  // Plaintext side
  aes_stream_source #(.CNT_W(CNT_W)) i_source (
    .clk          (clk),
    .reset_n      (reset_n),
    .start_i      (stream_start),
    .base_i       (src_base),
    .num_blocks_i (num_blocks),
    .rd_data_i    (rd_data_i),
    .hold_i       (eng_full),
    .rd_req_o     (rd_req_o),
    .rd_addr_o    (rd_addr_o),
    .blk_valid_o  (blk_valid),
    .blk_data_o   (blk_data),
    .done_o       (src_done)
  );

  aes_add_round_key i_engine (
    .clk         (clk),
    .reset_n     (reset_n),
    .clear_i     (engine_clear),
    .in_valid_i  (blk_valid),
    .in_block_i  (blk_data),
    .key_i       (key),
    .take_i      (take),
    .full_o      (eng_full),
    .out_block_o (eng_block)
  );

  // Ciphertext side
  aes_stream_sink #(.CNT_W(CNT_W)) i_sink (
    .clk          (clk),
    .reset_n      (reset_n),
    .start_i      (stream_start),
    .base_i       (dst_base),
    .num_blocks_i (num_blocks),
    .blk_full_i   (eng_full),
    .blk_data_i   (eng_block),
    .take_o       (take),
    .wr_req_o     (wr_req_o),
    .wr_addr_o    (wr_addr_o),
    .wr_data_o    (wr_data_o),
    .done_o       (snk_done)
  );

endmodule

// File: src/aes_stream_sink.sv
module aes_stream_sink #(
  parameter int unsigned CNT_W = 16
) (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             start_i,
  input  aes_pkg::addr_t   base_i,
  input  logic [CNT_W-1:0] num_blocks_i,
  input  logic             blk_full_i,
  input  aes_pkg::block_t  blk_data_i,
  output logic             take_o,
  output logic             wr_req_o,
  output aes_pkg::addr_t   wr_addr_o,
  output aes_pkg::word_t   wr_data_o,
  output logic             done_o
);

  localparam logic [1:0] LAST_IDX = 2'(aes_pkg::WORDS_PER_BLOCK - 1);

  aes_pkg::addr_t  cnt_addr;
  logic [1:0]      cnt_idx;
  logic            cnt_done;
  logic            active_q;
  aes_pkg::block_t blk_q;

  aes_addr_counter #(
    .CNT_W (CNT_W)
  ) i_addr_counter (
    .clk          (clk),
    .reset_n      (reset_n),
    .load_i       (start_i),
    .base_i       (base_i),
    .num_blocks_i (num_blocks_i),
    .step_i       (wr_req_o),
    .addr_o       (cnt_addr),
    .word_idx_o   (cnt_idx),
    .done_o       (cnt_done)
  );

  // Take a new block only between bursts
  assign take_o    = !active_q && blk_full_i;
  assign wr_req_o  = active_q;
  assign wr_addr_o = cnt_addr;
  assign wr_data_o = blk_q[32*cnt_idx +: 32];
  assign done_o    = cnt_done && !active_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q <= 1'b0;
    end else if (take_o) begin
      active_q <= 1'b1;
    end else if (active_q && (cnt_idx == LAST_IDX)) begin
      active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_o) begin
      blk_q <= blk_data_i;
    end
  end

endmodule

// File: src/aes_add_round_key.sv
module aes_add_round_key (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            clear_i,
  input  logic            in_valid_i,
  input  aes_pkg::block_t in_block_i,
  input  aes_pkg::block_t key_i,
  input  logic            take_i,
  output logic            full_o,
  output aes_pkg::block_t out_block_o
);

  logic            full_q;
  aes_pkg::block_t res_q;

  // A load in the same cycle as a take keeps the entry occupied
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      full_q <= 1'b0;
    end else if (clear_i) begin
      full_q <= 1'b0;
    end else if (in_valid_i) begin
      full_q <= 1'b1;
    end else if (take_i) begin
      full_q <= 1'b0;
    end
  end

  // AddRoundKey step
  always_ff @(posedge clk) begin
    if (in_valid_i) begin
      res_q <= in_block_i ^ key_i;
    end
  end

  assign full_o      = full_q;
  assign out_block_o = res_q;

  // Source back-pressure must keep a held result from being overwritten
  a_no_overwrite: assert property (@(posedge clk) disable iff (!reset_n)
    in_valid_i |-> (!full_o || take_i));

endmodule

// File: src/aes_stream_source.sv
module aes_stream_source #(
  parameter int unsigned CNT_W = 16
) (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             start_i,
  input  aes_pkg::addr_t   base_i,
  input  logic [CNT_W-1:0] num_blocks_i,
  input  aes_pkg::word_t   rd_data_i,
  input  logic             hold_i,
  output logic             rd_req_o,
  output aes_pkg::addr_t   rd_addr_o,
  output logic             blk_valid_o,
  output aes_pkg::block_t  blk_data_o,
  output logic             done_o
);

  localparam logic [1:0] LAST_IDX = 2'(aes_pkg::WORDS_PER_BLOCK - 1);

  aes_pkg::addr_t  cnt_addr;
  logic [1:0]      cnt_idx;
  logic            cnt_done;
  logic            pending_q;
  logic [1:0]      pend_idx_q;
  logic            have_blk_q;
  aes_pkg::block_t blk_q;
  logic            last_in_flight;
  logic            stall;

  aes_addr_counter #(
    .CNT_W (CNT_W)
  ) i_addr_counter (
    .clk          (clk),
    .reset_n      (reset_n),
    .load_i       (start_i),
    .base_i       (base_i),
    .num_blocks_i (num_blocks_i),
    .step_i       (rd_req_o),
    .addr_o       (cnt_addr),
    .word_idx_o   (cnt_idx),
    .done_o       (cnt_done)
  );

  // A new block may only start once the previous one has left the buffer
  assign last_in_flight = pending_q && (pend_idx_q == LAST_IDX);
  assign stall          = (cnt_idx == '0) && (last_in_flight || (have_blk_q && hold_i));
  assign rd_req_o       = !cnt_done && !stall;
  assign rd_addr_o      = cnt_addr;
  assign blk_valid_o    = have_blk_q && !hold_i;
  assign blk_data_o     = blk_q;
  assign done_o         = cnt_done && !pending_q && !have_blk_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pending_q  <= 1'b0;
      pend_idx_q <= '0;
      have_blk_q <= 1'b0;
    end else begin
      pending_q <= rd_req_o;
      if (rd_req_o) begin
        pend_idx_q <= cnt_idx;
      end
      if (last_in_flight) begin
        have_blk_q <= 1'b1;
      end else if (blk_valid_o) begin
        have_blk_q <= 1'b0;
      end
    end
  end

  // Read data lands one cycle after its request
  always_ff @(posedge clk) begin
    if (pending_q) begin
      blk_q[32*pend_idx_q +: 32] <= rd_data_i;
    end
  end

endmodule

// File: src/aes_fsm.sv
module aes_fsm (
  input  logic clk,
  input  logic reset_n,
  input  logic start_i,
  input  logic src_done_i,
  input  logic snk_done_i,
  input  logic eng_full_i,
  output logic stream_start_o,
  output logic engine_clear_o,
  output logic busy_o,
  output logic done_o
);

  aes_pkg::aes_state_t state_q;
  aes_pkg::aes_state_t state_d;
  logic                work_done;

  // Both streams drained and nothing left in the engine
  assign work_done = src_done_i && snk_done_i && !eng_full_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= aes_pkg::AES_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      aes_pkg::AES_IDLE: begin
        if (start_i) begin
          state_d = aes_pkg::AES_STARTING;
        end
      end
      aes_pkg::AES_STARTING: state_d = aes_pkg::AES_WORKING;
      aes_pkg::AES_WORKING: begin
        if (work_done) begin
          state_d = aes_pkg::AES_FINISHED;
        end
      end
      aes_pkg::AES_FINISHED: state_d = aes_pkg::AES_IDLE;
      default: state_d = aes_pkg::AES_IDLE;
    endcase
  end

  // Outputs decoded from state only
  always_comb begin
    engine_clear_o = 1'b0;
    stream_start_o = 1'b0;
    done_o         = 1'b0;
    case (state_q)
      aes_pkg::AES_IDLE:     engine_clear_o = 1'b1;
      aes_pkg::AES_STARTING: stream_start_o = 1'b1;
      aes_pkg::AES_FINISHED: done_o         = 1'b1;
      default: begin
      end
    endcase
  end

  assign busy_o = (state_q != aes_pkg::AES_IDLE);

  // Streams are launched only after the previous job has fully drained
  a_start_when_drained: assert property (@(posedge clk) disable iff (!reset_n)
    stream_start_o |-> (src_done_i && snk_done_i && !eng_full_i));

endmodule

// File: src/aes_regfile.sv
module aes_regfile #(
  parameter int unsigned CNT_W = 16
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              cfg_we_i,
  input  aes_pkg::reg_idx_t cfg_addr_i,
  input  aes_pkg::word_t    cfg_wdata_i,
  input  logic              busy_i,
  output aes_pkg::word_t    cfg_rdata_o,
  output logic              start_o,
  output aes_pkg::addr_t    src_base_o,
  output aes_pkg::addr_t    dst_base_o,
  output logic [CNT_W-1:0]  num_blocks_o,
  output aes_pkg::block_t   key_o
);

  aes_pkg::addr_t   src_base_q;
  aes_pkg::addr_t   dst_base_q;
  logic [CNT_W-1:0] num_blocks_q;
  aes_pkg::block_t  key_q;
  logic             cfg_wr;
  logic [1:0]       key_sel;

  // Configuration stays frozen while a job runs
  assign cfg_wr  = cfg_we_i && !busy_i;
  assign key_sel = 2'(cfg_addr_i - aes_pkg::REG_KEY0);
  assign start_o = cfg_wr && (cfg_addr_i == aes_pkg::REG_TRIGGER);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      src_base_q   <= '0;
      dst_base_q   <= '0;
      num_blocks_q <= '0;
      key_q        <= '0;
    end else if (cfg_wr) begin
      case (cfg_addr_i)
        aes_pkg::REG_SRC_BASE:   src_base_q   <= cfg_wdata_i;
        aes_pkg::REG_DST_BASE:   dst_base_q   <= cfg_wdata_i;
        aes_pkg::REG_NUM_BLOCKS: num_blocks_q <= cfg_wdata_i[CNT_W-1:0];
        aes_pkg::REG_KEY0, aes_pkg::REG_KEY1, aes_pkg::REG_KEY2, aes_pkg::REG_KEY3: begin
          key_q[32*key_sel +: 32] <= cfg_wdata_i;
        end
        default: begin
        end
      endcase
    end
  end

  // Host readback, trigger reads as zero
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      aes_pkg::REG_SRC_BASE:   cfg_rdata_o = src_base_q;
      aes_pkg::REG_DST_BASE:   cfg_rdata_o = dst_base_q;
      aes_pkg::REG_NUM_BLOCKS: cfg_rdata_o = aes_pkg::word_t'(num_blocks_q);
      aes_pkg::REG_KEY0, aes_pkg::REG_KEY1, aes_pkg::REG_KEY2, aes_pkg::REG_KEY3: begin
        cfg_rdata_o = key_q[32*key_sel +: 32];
      end
      aes_pkg::REG_STATUS:     cfg_rdata_o = aes_pkg::word_t'(busy_i);
      default: begin
        cfg_rdata_o = '0;
      end
    endcase
  end

  assign src_base_o   = src_base_q;
  assign dst_base_o   = dst_base_q;
  assign num_blocks_o = num_blocks_q;
  assign key_o        = key_q;

endmodule

// File: src/aes_addr_counter.sv
module aes_addr_counter #(
  parameter int unsigned CNT_W = 16
) (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             load_i,
  input  aes_pkg::addr_t   base_i,
  input  logic [CNT_W-1:0] num_blocks_i,
  input  logic             step_i,
  output aes_pkg::addr_t   addr_o,
  output logic [1:0]       word_idx_o,
  output logic             done_o
);

  aes_pkg::addr_t   addr_q;
  logic [CNT_W+1:0] remaining_q;
  logic [1:0]       idx_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      addr_q      <= '0;
      remaining_q <= '0;
      idx_q       <= '0;
    end else if (load_i) begin
      addr_q      <= base_i;
      remaining_q <= (CNT_W+2)'(num_blocks_i) * (CNT_W+2)'(aes_pkg::WORDS_PER_BLOCK);
      idx_q       <= '0;
    end else if (step_i) begin
      // One word is four bytes
      addr_q      <= addr_q + 32'd4;
      remaining_q <= remaining_q - 1'b1;
      idx_q       <= idx_q + 1'b1;
    end
  end

  assign addr_o     = addr_q;
  assign word_idx_o = idx_q;
  assign done_o     = (remaining_q == '0);

  // Streams must stop stepping once their transfer is complete
  a_no_step_when_done: assert property (@(posedge clk) disable iff (!reset_n)
    !(step_i && done_o));

endmodule

// File: src/aes_pkg.sv
package aes_pkg;

  // Bus and data widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // Word k of a block sits at bits 32k upward
  typedef logic [127:0] block_t;

  typedef logic [3:0] reg_idx_t;

  // Job controller states
  typedef enum logic [1:0] {
    AES_IDLE,
    AES_STARTING,
    AES_WORKING,
    AES_FINISHED
  } aes_state_t;

  // Register map
  localparam reg_idx_t REG_SRC_BASE   = 4'd0;
  localparam reg_idx_t REG_DST_BASE   = 4'd1;
  localparam reg_idx_t REG_NUM_BLOCKS = 4'd2;
  localparam reg_idx_t REG_KEY0       = 4'd3;
  localparam reg_idx_t REG_KEY1       = 4'd4;
  localparam reg_idx_t REG_KEY2       = 4'd5;
  localparam reg_idx_t REG_KEY3       = 4'd6;
  localparam reg_idx_t REG_TRIGGER    = 4'd7;
  localparam reg_idx_t REG_STATUS     = 4'd8;

  // Memory words in one cipher block
  localparam int unsigned WORDS_PER_BLOCK = 4;

endpackage
